// ==== include/host_bridge_defines.svh ====
`ifndef HOST_BRIDGE_DEFINES_SVH
`define HOST_BRIDGE_DEFINES_SVH

// stream and register data widths
`define HOST_WORD_W 32
`define HTIF_WORD_W 16

// queue sizing
`define FIFO_ADDR_W  5  // 32 entries
`define FIFO_COUNT_W 6  // holds 0 to 32

// processor bus
`define AXI_ID_W   12
`define AXI_ADDR_W 32

// word address bits that pick a register
`define REG_SEL_LSB 2
`define REG_SEL_MSB 6
`define REG_SEL_W   5

`endif

// ==== source/axi_port_pkg.sv ====
`include "host_bridge_defines.svh"

package axi_port_pkg;

  // same layout for the read address and write address channels
  typedef struct packed {
    logic [`AXI_ID_W-1:0]   id;
    logic [`AXI_ADDR_W-1:0] addr;
  } axi_addr_t;

  // one write beat
  typedef struct packed {
    logic [`HOST_WORD_W-1:0] data;
  } axi_wdata_t;

  // read response, always a single beat
  typedef struct packed {
    logic [`AXI_ID_W-1:0]    id;
    logic [`HOST_WORD_W-1:0] data;
    logic                    last;
  } axi_rresp_t;

  // write response
  typedef struct packed {
    logic [`AXI_ID_W-1:0] id;  // echo of the aw id
  } axi_bresp_t;

endpackage

// ==== source/host_reg_pkg.sv ====
`include "host_bridge_defines.svh"

package host_reg_pkg;

  // registers on the read side
  typedef enum logic [`REG_SEL_W-1:0] {
    rd_out_count      = 5'd0,  // host_out fill level
    rd_host_out_data  = 5'd1,
    rd_htif_out_count = 5'd2,
    rd_htif_out_data  = 5'd3,
    rd_host_in_count  = 5'd4,
    rd_htif_in_count  = 5'd5
  } rd_reg_e;

  // registers on the write side
  typedef enum logic [`REG_SEL_W-1:0] {
    wr_host_in_data = 5'd0,
    wr_htif_in_data = 5'd1,
    wr_chip_reset   = 5'd31  // one cycle pulse to the chip
  } wr_reg_e;

  // queue level as seen by the read port
  typedef struct packed {
    logic [`FIFO_COUNT_W-1:0] count;
  } fifo_status_t;

endpackage

// ==== source/bridge_fifo.sv ====
`timescale 1ns/1ns
`include "host_bridge_defines.svh"

module bridge_fifo import host_reg_pkg::*; #(
  parameter int WIDTH = 32
) (
  input  logic             host_clk,
  input  logic             reset,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data,
  output fifo_status_t     status
);

  localparam int DEPTH = 1 << `FIFO_ADDR_W;

  logic [WIDTH-1:0]         mem [DEPTH];
  logic [`FIFO_ADDR_W-1:0]  wr_ptr;
  logic [`FIFO_ADDR_W-1:0]  rd_ptr;
  logic [`FIFO_ADDR_W-1:0]  wr_ptr_next;
  logic [`FIFO_ADDR_W-1:0]  rd_ptr_next;
  logic                     empty;
  logic                     full;
  logic [`FIFO_COUNT_W-1:0] count;
  logic                     push;
  logic                     pop;

  assign in_ready  = !full;
  assign out_valid = !empty;
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  assign wr_ptr_next = push ? wr_ptr + `FIFO_ADDR_W'(1) : wr_ptr;
  assign rd_ptr_next = pop ? rd_ptr + `FIFO_ADDR_W'(1) : rd_ptr;

  assign out_data = mem[rd_ptr];  // oldest entry, no read latency
  assign status   = '{count: count};

  always_ff @(posedge host_clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge host_clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      empty  <= 1'b1;
      full   <= 1'b0;
      count  <= '0;
    end
    else
    begin
      wr_ptr <= wr_ptr_next;
      rd_ptr <= rd_ptr_next;

      // push and pop together leave the flags alone
      if (pop && !push && rd_ptr_next == wr_ptr)
        empty <= 1'b1;
      else if (push && !pop)
        empty <= 1'b0;

      if (push && !pop && wr_ptr_next == rd_ptr)
        full <= 1'b1;  // pointers met after a write
      else if (pop && !push)
        full <= 1'b0;

      if (push && !pop)
        count <= count + `FIFO_COUNT_W'(1);
      else if (pop && !push)
        count <= count - `FIFO_COUNT_W'(1);
    end
  end

endmodule

// ==== source/axi_read_port.sv ====
`timescale 1ns/1ns
`include "host_bridge_defines.svh"

module axi_read_port import axi_port_pkg::*, host_reg_pkg::*; (
  input  logic                    host_clk,
  input  logic                    reset,
  input  logic                    ar_valid,
  input  axi_addr_t               ar,
  output logic                    ar_ready,
  output logic                    r_valid,
  output axi_rresp_t              r,
  input  logic                    r_ready,
  input  logic [`HOST_WORD_W-1:0] host_out_data,
  input  logic [`HTIF_WORD_W-1:0] htif_out_data,
  output logic                    host_out_pop,
  output logic                    htif_out_pop,
  input  fifo_status_t            host_in_status,
  input  fifo_status_t            htif_in_status,
  input  fifo_status_t            host_out_status,
  input  fifo_status_t            htif_out_status
);

  localparam int CNT_PAD  = `HOST_WORD_W - `FIFO_COUNT_W;
  localparam int HTIF_PAD = `HOST_WORD_W - `HTIF_WORD_W;

  typedef enum logic {
    rd_idle,
    rd_resp
  } rd_state_e;

  rd_state_e               state;
  logic [`AXI_ID_W-1:0]    id_q;
  rd_reg_e                 sel_q;
  logic [`HOST_WORD_W-1:0] rd_data;
  logic                    ar_fire;
  logic                    r_fire;

  assign ar_ready = (state == rd_idle);  // low while a response waits
  assign r_valid  = (state == rd_resp);
  assign ar_fire  = ar_valid && ar_ready;
  assign r_fire   = r_valid && r_ready;

  always_ff @(posedge host_clk)
  begin
    if (reset)
      state <= rd_idle;
    else
    begin
      case (state)
        rd_idle:
          if (ar_fire)
            state <= rd_resp;
        rd_resp:
          if (r_ready)
            state <= rd_idle;
        default:
          state <= rd_idle;
      endcase
    end
  end

  // id and register selector of the pending read
  always_ff @(posedge host_clk)
  begin
    if (ar_fire)
    begin
      id_q  <= ar.id;
      sel_q <= rd_reg_e'(ar.addr[`REG_SEL_MSB:`REG_SEL_LSB]);
    end
  end

  always_comb
  begin
    case (sel_q)
      rd_out_count:      rd_data = {{CNT_PAD{1'b0}}, host_out_status.count};
      rd_host_out_data:  rd_data = host_out_data;
      rd_htif_out_count: rd_data = {{CNT_PAD{1'b0}}, htif_out_status.count};
      rd_htif_out_data:  rd_data = {{HTIF_PAD{1'b0}}, htif_out_data};
      rd_host_in_count:  rd_data = {{CNT_PAD{1'b0}}, host_in_status.count};
      rd_htif_in_count:  rd_data = {{CNT_PAD{1'b0}}, htif_in_status.count};
      default:           rd_data = '0;  // unmapped reads return zero
    endcase
  end

  assign r = '{id: id_q, data: rd_data, last: r_valid};

  // pop only once the master has taken the word
  assign host_out_pop = r_fire && (sel_q == rd_host_out_data);
  assign htif_out_pop = r_fire && (sel_q == rd_htif_out_data);

endmodule

// ==== source/axi_write_port.sv ====
`timescale 1ns/1ns
`include "host_bridge_defines.svh"

module axi_write_port import axi_port_pkg::*, host_reg_pkg::*; (
  input  logic                    host_clk,
  input  logic                    reset,
  input  logic                    aw_valid,
  input  logic                    w_valid,
  input  axi_addr_t               aw,
  input  axi_wdata_t              w,
  output logic                    aw_ready,
  output logic                    w_ready,
  output logic                    b_valid,
  output axi_bresp_t              b,
  input  logic                    b_ready,
  output logic                    host_in_push,
  output logic                    htif_in_push,
  input  logic                    host_in_ready,
  input  logic                    htif_in_ready,
  output logic [`HOST_WORD_W-1:0] push_data,
  output logic                    cpu_reset
);

  typedef enum logic [1:0] {
    wr_idle,
    wr_write,
    wr_ack
  } wr_state_e;

  wr_state_e               state;
  logic [`AXI_ID_W-1:0]    id_q;
  wr_reg_e                 sel_q;
  logic [`HOST_WORD_W-1:0] data_q;
  logic                    capture;
  logic                    target_ready;
  logic                    do_write;

  // address and data must both be present to start
  assign capture = (state == wr_idle) && aw_valid && w_valid;

  always_comb
  begin
    case (sel_q)
      wr_host_in_data: target_ready = host_in_ready;
      wr_htif_in_data: target_ready = htif_in_ready;
      default:         target_ready = 1'b1;  // reset and unmapped never stall
    endcase
  end

  assign do_write = (state == wr_write) && target_ready;

  always_ff @(posedge host_clk)
  begin
    if (reset)
      state <= wr_idle;
    else
    begin
      case (state)
        wr_idle:
          if (capture)
            state <= wr_write;
        wr_write:
          if (target_ready)
            state <= wr_ack;
        wr_ack:
          if (b_ready)
            state <= wr_idle;
        default:
          state <= wr_idle;
      endcase
    end
  end

  always_ff @(posedge host_clk)
  begin
    if (capture)
    begin
      id_q   <= aw.id;
      sel_q  <= wr_reg_e'(aw.addr[`REG_SEL_MSB:`REG_SEL_LSB]);
      data_q <= w.data;
    end
  end

  // the bus handshake lands in the same cycle as the push
  assign aw_ready = do_write;
  assign w_ready  = do_write;

  assign host_in_push = do_write && (sel_q == wr_host_in_data);
  assign htif_in_push = do_write && (sel_q == wr_htif_in_data);
  assign cpu_reset    = do_write && (sel_q == wr_chip_reset);
  assign push_data    = data_q;

  assign b_valid = (state == wr_ack);
  assign b       = '{id: id_q};

endmodule

// ==== source/host_bridge_top.sv ====
`timescale 1ns/1ns
`include "host_bridge_defines.svh"

module host_bridge_top import axi_port_pkg::*, host_reg_pkg::*; (
  input  logic                    host_clk,
  input  logic                    reset,
  // processor side
  input  logic                    ar_valid,
  input  axi_addr_t               ar,
  output logic                    ar_ready,
  output logic                    r_valid,
  output axi_rresp_t              r,
  input  logic                    r_ready,
  input  logic                    aw_valid,
  input  axi_addr_t               aw,
  output logic                    aw_ready,
  input  logic                    w_valid,
  input  axi_wdata_t              w,
  output logic                    w_ready,
  output logic                    b_valid,
  output axi_bresp_t              b,
  input  logic                    b_ready,
  // chip side
  output logic                    host_in_valid,
  input  logic                    host_in_ready,
  output logic [`HOST_WORD_W-1:0] host_in_bits,
  output logic                    htif_in_valid,
  input  logic                    htif_in_ready,
  output logic [`HTIF_WORD_W-1:0] htif_in_bits,
  input  logic                    host_out_valid,
  output logic                    host_out_ready,
  input  logic [`HOST_WORD_W-1:0] host_out_bits,
  input  logic                    htif_out_valid,
  output logic                    htif_out_ready,
  input  logic [`HTIF_WORD_W-1:0] htif_out_bits,
  output logic                    cpu_reset
);

  logic                    host_in_push;
  logic                    htif_in_push;
  logic                    host_in_room;  // in_ready of the in queues
  logic                    htif_in_room;
  logic [`HOST_WORD_W-1:0] push_data;
  logic                    host_out_pop;
  logic                    htif_out_pop;
  logic [`HOST_WORD_W-1:0] host_out_data;
  logic [`HTIF_WORD_W-1:0] htif_out_data;
  fifo_status_t            host_in_status;
  fifo_status_t            htif_in_status;
  fifo_status_t            host_out_status;
  fifo_status_t            htif_out_status;

  axi_read_port u_axi_read_port (
    .host_clk, .reset, .ar_valid, .ar, .ar_ready, .r_valid, .r, .r_ready,
    .host_out_data, .htif_out_data, .host_out_pop, .htif_out_pop,
    .host_in_status, .htif_in_status, .host_out_status, .htif_out_status
  );

  axi_write_port u_axi_write_port (
    .host_clk, .reset, .aw_valid, .w_valid, .aw, .w, .aw_ready, .w_ready,
    .b_valid, .b, .b_ready, .host_in_push, .htif_in_push,
    .host_in_ready(host_in_room), .htif_in_ready(htif_in_room), .push_data, .cpu_reset
  );

  // processor to chip
  bridge_fifo #(.WIDTH(`HOST_WORD_W)) u_host_in_fifo (
    .host_clk, .reset, .in_valid(host_in_push), .in_ready(host_in_room),
    .in_data(push_data), .out_valid(host_in_valid), .out_ready(host_in_ready),
    .out_data(host_in_bits), .status(host_in_status)
  );

  bridge_fifo #(.WIDTH(`HTIF_WORD_W)) u_htif_in_fifo (
    .host_clk, .reset, .in_valid(htif_in_push), .in_ready(htif_in_room),
    .in_data(push_data[`HTIF_WORD_W-1:0]), .out_valid(htif_in_valid),
    .out_ready(htif_in_ready), .out_data(htif_in_bits), .status(htif_in_status)
  );

  // chip to processor
  bridge_fifo #(.WIDTH(`HOST_WORD_W)) u_host_out_fifo (
    .host_clk, .reset, .in_valid(host_out_valid), .in_ready(host_out_ready),
    .in_data(host_out_bits), .out_valid(), .out_ready(host_out_pop),
    .out_data(host_out_data), .status(host_out_status)
  );

  bridge_fifo #(.WIDTH(`HTIF_WORD_W)) u_htif_out_fifo (
    .host_clk, .reset, .in_valid(htif_out_valid), .in_ready(htif_out_ready),
    .in_data(htif_out_bits), .out_valid(), .out_ready(htif_out_pop),
    .out_data(htif_out_data), .status(htif_out_status)
  );

endmodule

// ==== tb/host_bridge_tb.sv ====
`timescale 1ns/1ns
`include "host_bridge_defines.svh"

module host_bridge_tb import axi_port_pkg::*, host_reg_pkg::*; ();

  localparam int MAX_CYCLES = 20000;  // all tests together take well under 2000 cycles

  logic host_clk, reset;
  logic ar_valid, ar_ready, r_valid, r_ready;
  logic aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  axi_addr_t  ar, aw;
  axi_wdata_t w;
  axi_rresp_t r;
  axi_bresp_t b;
  logic host_in_valid, host_in_ready, htif_in_valid, htif_in_ready;
  logic host_out_valid, host_out_ready, htif_out_valid, htif_out_ready;
  logic [`HOST_WORD_W-1:0] host_in_bits, host_out_bits;
  logic [`HTIF_WORD_W-1:0] htif_in_bits, htif_out_bits;
  logic cpu_reset;

  integer seed = 32'he8e03881;
  int error_count, tests_passed, tests_failed, cycle_count, reset_pulses;
  int ready_mode;  // chip in-ready: 0 low, 1 random, 2 high
  bit req_seen;
  logic [`HOST_WORD_W-1:0] host_in_model[$], host_out_model[$];
  logic [`HTIF_WORD_W-1:0] htif_in_model[$], htif_out_model[$];

  host_bridge_top u_host_bridge_top (.*);

  initial
  begin
    host_clk = 1'b0;
    forever #50 host_clk = ~host_clk;
  end

  initial
  begin
    while (cycle_count < MAX_CYCLES)
    begin
      @(posedge host_clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // chip side ready for the in streams
  initial
  begin
    int mode;
    host_in_ready = 1'b0;
    htif_in_ready = 1'b0;
    forever
    begin
      @(posedge host_clk);
      mode = ready_mode;  // taken at the edge, applied with the other inputs
      #10;
      host_in_ready = (mode == 2) || (mode == 1 && $random(seed) % 2 != 0);
      htif_in_ready = (mode == 2) || (mode == 1 && $random(seed) % 2 != 0);
    end
  end

  always @(posedge host_clk)
  begin
    if (host_in_valid && host_in_ready)
    begin
      assert (host_in_model.size() > 0 && host_in_bits == host_in_model[0])
      else log_error($sformatf("host_in delivered %h out of order", host_in_bits));
      void'(host_in_model.pop_front());
    end
    if (htif_in_valid && htif_in_ready)
    begin
      assert (htif_in_model.size() > 0 && htif_in_bits == htif_in_model[0])
      else log_error($sformatf("htif_in delivered %h out of order", htif_in_bits));
      void'(htif_in_model.pop_front());
    end
    if (!reset && cpu_reset)
      reset_pulses++;
    assert (reset || req_seen || (!r_valid && !b_valid && !cpu_reset))
    else log_error("response or cpu_reset seen before any request");
  end

  assert property (@(posedge host_clk) disable iff (reset) cpu_reset |=> !cpu_reset)
    else log_error("cpu_reset high for more than one cycle");
  assert property (@(posedge host_clk) disable iff (reset)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else log_error("read response changed before r_ready");
  assert property (@(posedge host_clk) disable iff (reset)
    b_valid && !b_ready |=> b_valid && $stable(b))
    else log_error("write response changed before b_ready");
  assert property (@(posedge host_clk) aw_ready == w_ready)
    else log_error("aw_ready and w_ready differ");

  task automatic log_error(input string msg);
    $display("** Error: %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic next_cycle();
    @(posedge host_clk);
    #10;
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (error_count == errs_before)
      tests_passed++;
    else
      tests_failed++;
    $display("%s: %s", name, (error_count == errs_before) ? "ok" : "failed");
  endtask

  task automatic reg_read(input logic [`REG_SEL_W-1:0] sel, output logic [31:0] data);
    logic [`AXI_ID_W-1:0] id;
    bit accepted;
    int stall;
    id = `AXI_ID_W'($random(seed));
    stall = 1 + $unsigned($random(seed)) % 3;  // cycles before the master takes r
    accepted = 1'b0;
    req_seen = 1'b1;
    ar = '{id: id, addr: `AXI_ADDR_W'(sel) << `REG_SEL_LSB};
    ar_valid = 1'b1;
    while (!accepted)
    begin
      @(negedge host_clk);
      accepted = ar_ready;
      next_cycle();
    end
    ar_valid = 1'b0;
    @(negedge host_clk);
    assert (r_valid && r.id == id && r.last)  // one cycle after the ar handshake
    else log_error($sformatf("read response valid %b id %h, expected id %h", r_valid, r.id, id));
    while (!r_valid)
      @(negedge host_clk);
    data = r.data;
    repeat (stall)
      next_cycle();
    r_ready = 1'b1;
    next_cycle();
    r_ready = 1'b0;
  endtask

  task automatic check_read(input logic [`REG_SEL_W-1:0] sel, input logic [31:0] expected);
    logic [31:0] data;
    reg_read(sel, data);
    assert (data == expected)
    else log_error($sformatf("register %0d read %h, expected %h", sel, data, expected));
  endtask

  task automatic reg_write(input logic [`REG_SEL_W-1:0] sel, input logic [31:0] data,
                           input bit fast);
    logic [`AXI_ID_W-1:0] id;
    bit accepted;
    int waits;
    int stall;
    id = `AXI_ID_W'($random(seed));
    stall = 1 + $unsigned($random(seed)) % 3;  // cycles before the master takes b
    accepted = 1'b0;
    waits = 0;
    req_seen = 1'b1;
    aw = '{id: id, addr: `AXI_ADDR_W'(sel) << `REG_SEL_LSB};
    w = '{data: data};
    aw_valid = 1'b1;
    w_valid = 1'b1;
    while (!accepted)
    begin
      @(negedge host_clk);
      accepted = aw_ready;
      waits++;
      next_cycle();
    end
    aw_valid = 1'b0;
    w_valid = 1'b0;
    @(negedge host_clk);
    assert ((!fast || waits == 2) && b_valid && b.id == id)  // capture to b_valid is 2 cycles
    else log_error($sformatf("write took %0d cycles, bid %h, expected %h", waits, b.id, id));
    while (!b_valid)
      @(negedge host_clk);
    repeat (stall)
      next_cycle();
    b_ready = 1'b1;
    next_cycle();
    b_ready = 1'b0;
  endtask

  task automatic chip_push(input bit htif, input logic [31:0] data);
    bit taken;
    taken = 1'b0;
    host_out_valid = !htif;
    htif_out_valid = htif;
    host_out_bits = data;
    htif_out_bits = data[15:0];
    if (htif)
      htif_out_model.push_back(data[15:0]);
    else
      host_out_model.push_back(data);
    while (!taken)
    begin
      @(negedge host_clk);
      taken = htif ? htif_out_ready : host_out_ready;
      next_cycle();
    end
    host_out_valid = 1'b0;
    htif_out_valid = 1'b0;
  endtask

  task automatic drain_in_queues();
    ready_mode = 1;
    while (host_in_model.size() > 0 || htif_in_model.size() > 0)
      next_cycle();
    ready_mode = 0;
    next_cycle();
  endtask

  initial
  begin
    logic [31:0] data;
    int errs;
    int pulses;
    reset = 1'b1;
    {ar_valid, r_ready, aw_valid, w_valid, b_ready} = '0;
    ar = '0;
    aw = '0;
    w = '0;
    {host_out_valid, htif_out_valid, host_out_bits, htif_out_bits} = '0;
    repeat (16) @(posedge host_clk);
    #10;
    reset = 1'b0;

    errs = error_count;
    repeat (3) next_cycle();  // quiet window before the first request
    assert (ar_ready && !aw_ready && host_out_ready && htif_out_ready && !host_in_valid &&
            !htif_in_valid)
    else log_error("bridge outputs not idle after reset");
    check_read(rd_out_count, 0);
    check_read(rd_htif_out_count, 0);
    check_read(rd_host_in_count, 0);
    check_read(rd_htif_in_count, 0);
    end_test("reset state", errs);

    errs = error_count;
    for (int i = 0; i < 8; i++)
    begin
      data = $random(seed);
      host_in_model.push_back(data);
      reg_write(wr_host_in_data, data, 1'b1);
    end
    check_read(rd_host_in_count, 8);
    drain_in_queues();
    check_read(rd_host_in_count, 0);
    end_test("host_in path", errs);

    errs = error_count;
    for (int i = 0; i < 8; i++)
    begin
      data = $random(seed);
      htif_in_model.push_back(data[15:0]);  // only the low half reaches the chip
      reg_write(wr_htif_in_data, data, 1'b1);
    end
    check_read(rd_htif_in_count, 8);
    drain_in_queues();
    check_read(rd_htif_in_count, 0);
    end_test("htif_in path", errs);

    errs = error_count;
    for (int i = 0; i < 6; i++)
    begin
      chip_push(1'b0, $random(seed));
      chip_push(1'b1, $random(seed));
    end
    for (int i = 6; i > 0; i--)
    begin
      check_read(rd_out_count, i);
      check_read(rd_host_out_data, host_out_model.pop_front());
      check_read(rd_htif_out_count, i);
      check_read(rd_htif_out_data, {16'h0, htif_out_model.pop_front()});
    end
    check_read(rd_out_count, 0);
    end_test("out queues", errs);

    errs = error_count;
    for (int i = 0; i < 32; i++)
    begin
      data = $random(seed);
      host_in_model.push_back(data);
      reg_write(wr_host_in_data, data, 1'b1);
    end
    data = $random(seed);
    host_in_model.push_back(data);
    fork
      reg_write(wr_host_in_data, data, 1'b0);
      begin
        repeat (8)
        begin
          @(negedge host_clk);
          assert (!aw_ready && !b_valid) else log_error("write to a full host_in queue finished");
        end
        next_cycle();
        ready_mode = 2;  // chip takes exactly one word
        next_cycle();
        ready_mode = 0;
      end
    join
    check_read(rd_host_in_count, 32);
    drain_in_queues();
    for (int i = 0; i < 32; i++)
      chip_push(1'b0, $random(seed));
    @(negedge host_clk);
    assert (!host_out_ready) else log_error("host_out_ready high with 32 words queued");
    next_cycle();
    check_read(rd_host_out_data, host_out_model.pop_front());
    @(negedge host_clk);
    assert (host_out_ready) else log_error("host_out_ready still low after a read");
    next_cycle();
    while (host_out_model.size() > 0)
      check_read(rd_host_out_data, host_out_model.pop_front());
    end_test("back-pressure", errs);

    errs = error_count;
    chip_push(1'b0, $random(seed));
    chip_push(1'b1, $random(seed));
    data = $random(seed);
    host_in_model.push_back(data);
    reg_write(wr_host_in_data, data, 1'b1);
    pulses = reset_pulses;
    reg_write(wr_chip_reset, 32'h0, 1'b1);
    assert (reset_pulses == pulses + 1)
    else log_error($sformatf("saw %0d cpu_reset pulses, expected 1", reset_pulses - pulses));
    check_read(rd_out_count, 1);
    check_read(rd_htif_out_count, 1);
    check_read(rd_host_in_count, 1);
    check_read(rd_host_out_data, host_out_model.pop_front());
    check_read(rd_htif_out_data, {16'h0, htif_out_model.pop_front()});
    drain_in_queues();
    end_test("chip reset", errs);

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && error_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
source/axi_port_pkg.sv
source/host_reg_pkg.sv
source/bridge_fifo.sv
source/axi_read_port.sv
source/axi_write_port.sv
source/host_bridge_top.sv
tb/host_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the host bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f sources.f --top-module host_bridge_tb -Mdir "$BUILD_DIR" -o host_bridge_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"$BUILD_DIR/host_bridge_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
  exit 0
else
  exit 1
fi
